// File: bench/fsync_checker.sv
// Scoreboard for the synchronization node
// Models the arrival tables from the request strobes and matches wakes
// and parent requests against the expected counts

`timescale 1ns/1ps

module fsync_checker
  import fsync_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  burst_i,
  input  logic [1:0]            en_valid_i,
  input  logic [1:0][REQ_W-1:0] en_req_i,
  input  logic [1:0]            ws_valid_i,
  input  logic [1:0][REQ_W-1:0] ws_req_i,
  input  logic [1:0]            rsp_valid_i,
  input  logic [1:0][ID_W-1:0]  rsp_id_i,
  input  logic [1:0]            out_valid_i,
  input  logic [1:0][REQ_W-1:0] out_req_i,
  input  logic [1:0]            wake_valid_i,
  input  logic [1:0][ID_W-1:0]  wake_id_i,
  input  logic                  error_i
);

  int         err_cnt = 0;
  int         pending = 0; // Outputs still owed by the DUT
  int         exp_wake [2][N_IDS];
  int         exp_req  [2][2**REQ_W];
  logic [1:0] loc_tab  [2][N_IDS];
  logic [1:0] rem_tab  [2][N_IDS];
  logic       ovf_seen = 1'b0;

  initial begin
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < N_IDS; i++) begin
        exp_wake[d][i] = 0;
        loc_tab[d][i]  = 2'b00;
        rem_tab[d][i]  = 2'b00;
      end
      for (int i = 0; i < 2**REQ_W; i++) exp_req[d][i] = 0;
    end
  end

  // Side 0 is EN and side 1 is WS
  task automatic arrive(input int d, input int side, input logic [REQ_W-1:0] req);
    logic [AGGR_W-1:0] aggr;
    logic [ID_W-1:0]   id;
    logic [1:0]        mine;
    aggr = req[REQ_W-1:ID_W];
    id   = req[ID_W-1:0];
    mine = (side == 1) ? 2'b10 : 2'b01;
    if (aggr[AGGR_W-1:1] == '0) begin
      if ((loc_tab[d][id] & ~mine) != 2'b00) begin
        loc_tab[d][id] = 2'b00;
        exp_wake[d][id]++;
        pending++;
      end else begin
        loc_tab[d][id] = loc_tab[d][id] | mine;
      end
    end else if ((rem_tab[d][id] & ~mine) != 2'b00) begin
      rem_tab[d][id] = 2'b00;
      exp_req[d][{aggr >> 1, id}]++; // Parent sees the next level of the aggregate
      pending++;
    end else begin
      rem_tab[d][id] = rem_tab[d][id] | mine;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni && !burst_i) begin
      for (int d = 0; d < 2; d++) begin
        // Outputs are matched before the arrivals of the same edge so an early wake finds no partner
        if (wake_valid_i[d]) begin
          if (exp_wake[d][wake_id_i[d]] > 0) begin
            exp_wake[d][wake_id_i[d]]--;
            pending--;
          end else begin
            $display("Error at %0t: dim %0d unexpected wake id %0h", $time, d, wake_id_i[d]);
            err_cnt++;
          end
        end
        if (out_valid_i[d]) begin
          if (exp_req[d][out_req_i[d]] > 0) begin
            exp_req[d][out_req_i[d]]--;
            pending--;
          end else begin
            $display("Error at %0t: dim %0d unexpected parent request %0h", $time, d,
                     out_req_i[d]);
            err_cnt++;
          end
        end
        if (en_valid_i[d]) arrive(d, 0, en_req_i[d]);
        if (ws_valid_i[d]) arrive(d, 1, ws_req_i[d]);
        if (rsp_valid_i[d]) begin
          exp_wake[d][rsp_id_i[d]]++;
          pending++;
        end
      end
      if (error_i && !ovf_seen) begin
        $display("Error at %0t: error_o raised before the overflow burst", $time);
        err_cnt++;
        ovf_seen = 1'b1; // Report it once
      end
    end else if (rst_ni) begin
      if (error_i) ovf_seen = 1'b1;
      else if (ovf_seen) begin
        $display("Error at %0t: error_o dropped after it was raised", $time);
        err_cnt++;
      end
    end
  end

  task automatic final_check();
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < N_IDS; i++) begin
        if (exp_wake[d][i] != 0) begin
          $display("Dimension %0d never sent the wake with id %0h", d, i);
          err_cnt++;
        end
      end
      for (int i = 0; i < 2**REQ_W; i++) begin
        if (exp_req[d][i] != 0) begin
          $display("Dimension %0d never sent the parent request %0h", d, i);
          err_cnt++;
        end
      end
    end
    if (!error_i) begin
      $display("The overflow burst did not raise error_o");
      err_cnt++;
    end
  endtask

endmodule

// File: bench/fsync_trace.txt
# gap dim port aggr id : gap is falling edges before the event, 0 keeps the previous cycle
# port 0 EN, 1 WS, 2 parent wake, 3 start of overflow burst; aggr and id in hex
2 0 0 1 3
8 0 1 1 3
8 0 0 6 5
8 0 1 6 5
8 1 2 0 a
8 1 0 0 7
0 1 1 0 7
0 1 2 0 c
8 0 0 1 2
0 1 1 1 2
4 0 0 1 2
4 0 0 1 4
4 1 0 1 2
4 0 1 1 4
4 0 1 1 2
6 1 0 e 1
6 1 1 e 1
30 0 3 0 0
1 0 0 1 9
0 0 1 1 9
1 0 0 1 9
0 0 1 1 9
1 0 0 1 9
0 0 1 1 9
1 0 0 1 9
0 0 1 1 9
1 0 0 1 9
0 0 1 1 9
1 0 0 1 9
0 0 1 1 9
1 0 0 1 9
0 0 1 1 9
1 0 0 1 9
0 0 1 1 9

// File: bench/tb_fsync_node.sv
// Testbench for the two-dimensional synchronization node
// Replays the event trace on falling edges and reports the checker result

`timescale 1ns/1ps

module tb_fsync_node
  import fsync_pkg::*;
();

  logic                  clk, rst_n, burst;
  logic [1:0]            en_valid, ws_valid, rsp_valid, out_valid, wake_valid;
  logic [1:0][REQ_W-1:0] en_req, ws_req, out_req;
  logic [1:0][ID_W-1:0]  rsp_id, wake_id;
  logic                  error;
  int                    gap_q[$], dim_q[$], port_q[$], aggr_q[$], id_q[$];
  int                    limit = 0;
  int                    cycles = 0;
  int                    tb_errs = 0;

  fsync_node #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk_i(clk), .rst_ni(rst_n),
    .h_en_req_valid_i(en_valid[DIM_H]), .h_en_req_i(en_req[DIM_H]),
    .h_ws_req_valid_i(ws_valid[DIM_H]), .h_ws_req_i(ws_req[DIM_H]),
    .h_req_out_valid_o(out_valid[DIM_H]), .h_req_out_o(out_req[DIM_H]),
    .h_rsp_in_valid_i(rsp_valid[DIM_H]), .h_rsp_in_id_i(rsp_id[DIM_H]),
    .h_wake_valid_o(wake_valid[DIM_H]), .h_wake_id_o(wake_id[DIM_H]),
    .v_en_req_valid_i(en_valid[DIM_V]), .v_en_req_i(en_req[DIM_V]),
    .v_ws_req_valid_i(ws_valid[DIM_V]), .v_ws_req_i(ws_req[DIM_V]),
    .v_req_out_valid_o(out_valid[DIM_V]), .v_req_out_o(out_req[DIM_V]),
    .v_rsp_in_valid_i(rsp_valid[DIM_V]), .v_rsp_in_id_i(rsp_id[DIM_V]),
    .v_wake_valid_o(wake_valid[DIM_V]), .v_wake_id_o(wake_id[DIM_V]),
    .error_o(error)
  );

  fsync_checker u_checker (
    .clk_i(clk), .rst_ni(rst_n), .burst_i(burst),
    .en_valid_i(en_valid), .en_req_i(en_req), .ws_valid_i(ws_valid), .ws_req_i(ws_req),
    .rsp_valid_i(rsp_valid), .rsp_id_i(rsp_id), .out_valid_i(out_valid),
    .out_req_i(out_req), .wake_valid_i(wake_valid), .wake_id_i(wake_id), .error_i(error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic read_trace();
    int    fd, r, g, d, p, a, i;
    string line;
    fd = $fopen("bench/fsync_trace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%d %d %d %h %h", g, d, p, a, i) == 5) begin
            gap_q.push_back(g);
            dim_q.push_back(d);
            port_q.push_back(p);
            aggr_q.push_back(a);
            id_q.push_back(i);
          end
        end
      end
      $fclose(fd);
    end
    if (gap_q.size() == 0) begin
      $display("Could not read any event from the trace file");
      tb_errs++;
    end
  endtask

  task automatic clear_strobes();
    en_valid  = '0;
    ws_valid  = '0;
    rsp_valid = '0;
  endtask

  task automatic drive_event(input int k);
    int d;
    d = dim_q[k];
    case (port_q[k])
      0: begin
        en_valid[d] = 1'b1;
        en_req[d]   = {AGGR_W'(aggr_q[k]), ID_W'(id_q[k])};
      end
      1: begin
        ws_valid[d] = 1'b1;
        ws_req[d]   = {AGGR_W'(aggr_q[k]), ID_W'(id_q[k])};
      end
      2: begin
        rsp_valid[d] = 1'b1;
        rsp_id[d]    = ID_W'(id_q[k]);
      end
      default: burst = 1'b1; // Checker stops modelling from here on
    endcase
  endtask

  // Run limit grows with the trace
  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT did not finish the trace", cycles);
    u_checker.final_check();
    $display("Errors: checker %0d, testbench %0d", u_checker.err_cnt, tb_errs);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    clear_strobes();
    en_req = '0;
    ws_req = '0;
    rsp_id = '0;
    burst  = 1'b0;
    rst_n  = 1'b0;
    read_trace();
    limit = 20 * gap_q.size() + 200;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int k = 0; k < gap_q.size(); k++) begin
      repeat (gap_q[k]) begin
        @(negedge clk);
        clear_strobes(); // Gap 0 keeps the event in the previous cycle
      end
      drive_event(k);
    end
    @(negedge clk);
    clear_strobes();
    while (!(u_checker.pending == 0 && (!burst || error))) @(negedge clk);
    repeat (20) @(negedge clk); // error_o must stay high while the burst drains
    u_checker.final_check();
    $display("Errors: checker %0d, testbench %0d", u_checker.err_cnt, tb_errs);
    if (u_checker.err_cnt + tb_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: hw/fsync_arbiter.sv
// Two-input round-robin arbiter for wake queues
// Pops one non-empty queue per cycle and strobes its id out

`timescale 1ns/1ps

module fsync_arbiter
  import fsync_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [1:0]          empty_i,
  input  logic [1:0][ID_W-1:0] data_i,
  output logic [1:0]          pop_o,
  output logic                valid_o,
  output logic [ID_W-1:0]     data_o
);

  logic rr_q; // Input that wins when both are pending
  logic grant;

  always_comb begin
    if (empty_i[0]) begin
      grant = 1'b1;
    end else if (empty_i[1]) begin
      grant = 1'b0;
    end else begin
      grant = rr_q;
    end
  end

  assign valid_o = ~&empty_i;
  assign pop_o   = {grant, ~grant} & {2{valid_o}};
  assign data_o  = data_i[grant];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= 1'b0;
    end else if (valid_o) begin
      rr_q <= ~grant; // Move past the granted input
    end
  end

endmodule

// File: hw/fsync_cc.sv
// Control core of one dimension
// Matches EN and WS arrivals per id in a local and a remote table
// and pushes completions to the wake queue or the parent queue

`timescale 1ns/1ps

module fsync_cc
  import fsync_pkg::*;
#(
  parameter int unsigned DEPTH = FIFO_DEPTH
)(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             en_empty_i,
  input  logic             en_local_i,
  input  logic [REQ_W-1:0] en_req_i,
  output logic             en_pop_o,
  input  logic             ws_empty_i,
  input  logic             ws_local_i,
  input  logic [REQ_W-1:0] ws_req_i,
  output logic             ws_pop_o,
  output logic             req_out_valid_o,
  output logic [REQ_W-1:0] req_out_o,
  output logic             wake_empty_o,
  output logic [ID_W-1:0]  wake_id_o,
  input  logic             wake_pop_i,
  output logic             overflow_o
);

  // Entry bit 0 marks an EN arrival, bit 1 a WS arrival
  logic [1:0] local_tab_q  [N_IDS];
  logic [1:0] remote_tab_q [N_IDS];

  logic             prio_ws_q;
  logic             sel_ws, do_pop, sel_local, complete;
  logic [REQ_W-1:0] sel_req;
  logic [ID_W-1:0]  sel_id;
  logic [1:0]       own_bit, entry;
  logic             parent_empty, wake_ovf, parent_ovf;

  assign sel_ws    = ~ws_empty_i & (en_empty_i | prio_ws_q);
  assign do_pop    = ~en_empty_i | ~ws_empty_i;
  assign en_pop_o  = do_pop & ~sel_ws;
  assign ws_pop_o  = do_pop & sel_ws;

  assign sel_req   = sel_ws ? ws_req_i : en_req_i;
  assign sel_local = sel_ws ? ws_local_i : en_local_i;
  assign sel_id    = sel_req[ID_W-1:0];
  assign own_bit   = sel_ws ? 2'b10 : 2'b01;
  assign entry     = sel_local ? local_tab_q[sel_id] : remote_tab_q[sel_id];

  // The partner is already in when the opposite bit is set
  assign complete  = do_pop & |(entry & ~own_bit);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_ws_q <= 1'b0;
      for (int i = 0; i < N_IDS; i++) begin
        local_tab_q[i]  <= 2'b00;
        remote_tab_q[i] <= 2'b00;
      end
    end else if (do_pop) begin
      prio_ws_q <= ~sel_ws; // Other side goes first next time
      if (sel_local) begin
        local_tab_q[sel_id] <= complete ? 2'b00 : (entry | own_bit);
      end else begin
        remote_tab_q[sel_id] <= complete ? 2'b00 : (entry | own_bit);
      end
    end
  end

  fsync_fifo #(
    .DEPTH ( DEPTH ),
    .WIDTH ( ID_W  )
  ) i_wake_fifo (
    .clk_i      ( clk_i                  ),
    .rst_ni     ( rst_ni                 ),
    .push_i     ( complete & sel_local   ),
    .data_i     ( sel_id                 ),
    .pop_i      ( wake_pop_i             ),
    .empty_o    ( wake_empty_o           ),
    .data_o     ( wake_id_o              ),
    .overflow_o ( wake_ovf               )
  );

  fsync_fifo #(
    .DEPTH ( DEPTH ),
    .WIDTH ( REQ_W )
  ) i_parent_fifo (
    .clk_i      ( clk_i                  ),
    .rst_ni     ( rst_ni                 ),
    .push_i     ( complete & ~sel_local  ),
    .data_i     ( sel_req                ),
    .pop_i      ( ~parent_empty          ),
    .empty_o    ( parent_empty           ),
    .data_o     ( req_out_o              ),
    .overflow_o ( parent_ovf             )
  );

  assign req_out_valid_o = ~parent_empty; // Drains one entry per cycle
  assign overflow_o      = wake_ovf | parent_ovf;

endmodule

// File: hw/fsync_fifo.sv
// Synchronous FIFO for the synchronization node
// A push while full is dropped and raises a sticky overflow flag

`timescale 1ns/1ps

module fsync_fifo
  import fsync_pkg::*;
#(
  parameter int unsigned DEPTH = FIFO_DEPTH,
  parameter int unsigned WIDTH = REQ_W
)(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic             empty_o,
  output logic [WIDTH-1:0] data_o,
  output logic             overflow_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             overflow_q;
  logic             full, do_push, do_pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o; // Pop on empty is ignored

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)      count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
      overflow_q <= overflow_q | (push_i & full); // Sticky until reset
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

  assign data_o     = mem[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

// File: hw/fsync_node.sv
// Two-dimensional fractal synchronization node
// Each dimension has EN and WS children and one parent port

`timescale 1ns/1ps

module fsync_node
  import fsync_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = fsync_pkg::FIFO_DEPTH
)(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             h_en_req_valid_i,
  input  logic [REQ_W-1:0] h_en_req_i,
  input  logic             h_ws_req_valid_i,
  input  logic [REQ_W-1:0] h_ws_req_i,
  output logic             h_req_out_valid_o,
  output logic [REQ_W-1:0] h_req_out_o,
  input  logic             h_rsp_in_valid_i,
  input  logic [ID_W-1:0]  h_rsp_in_id_i,
  output logic             h_wake_valid_o,
  output logic [ID_W-1:0]  h_wake_id_o,
  input  logic             v_en_req_valid_i,
  input  logic [REQ_W-1:0] v_en_req_i,
  input  logic             v_ws_req_valid_i,
  input  logic [REQ_W-1:0] v_ws_req_i,
  output logic             v_req_out_valid_o,
  output logic [REQ_W-1:0] v_req_out_o,
  input  logic             v_rsp_in_valid_i,
  input  logic [ID_W-1:0]  v_rsp_in_id_i,
  output logic             v_wake_valid_o,
  output logic [ID_W-1:0]  v_wake_id_o,
  output logic             error_o
);

  logic [1:0]            en_valid, ws_valid, rsp_valid, out_valid, wake_valid;
  logic [1:0][REQ_W-1:0] en_req, ws_req, out_req;
  logic [1:0][ID_W-1:0]  rsp_id, wake_id;
  logic [1:0][3:0]       ovf; // RX EN, RX WS, control core, TX per dimension

  assign en_valid[DIM_H]  = h_en_req_valid_i;
  assign en_valid[DIM_V]  = v_en_req_valid_i;
  assign en_req[DIM_H]    = h_en_req_i;
  assign en_req[DIM_V]    = v_en_req_i;
  assign ws_valid[DIM_H]  = h_ws_req_valid_i;
  assign ws_valid[DIM_V]  = v_ws_req_valid_i;
  assign ws_req[DIM_H]    = h_ws_req_i;
  assign ws_req[DIM_V]    = v_ws_req_i;
  assign rsp_valid[DIM_H] = h_rsp_in_valid_i;
  assign rsp_valid[DIM_V] = v_rsp_in_valid_i;
  assign rsp_id[DIM_H]    = h_rsp_in_id_i;
  assign rsp_id[DIM_V]    = v_rsp_in_id_i;

  assign h_req_out_valid_o = out_valid[DIM_H];
  assign h_req_out_o       = out_req[DIM_H];
  assign h_wake_valid_o    = wake_valid[DIM_H];
  assign h_wake_id_o       = wake_id[DIM_H];
  assign v_req_out_valid_o = out_valid[DIM_V];
  assign v_req_out_o       = out_req[DIM_V];
  assign v_wake_valid_o    = wake_valid[DIM_V];
  assign v_wake_id_o       = wake_id[DIM_V];

  for (genvar d = 0; d < 2; d++) begin : gen_dim
    logic             en_empty, en_local, en_pop, ws_empty, ws_local, ws_pop;
    logic [REQ_W-1:0] en_head, ws_head;
    logic             cc_wake_empty, tx_empty;
    logic [ID_W-1:0]  cc_wake_id, tx_id;
    logic [1:0]       arb_pop;

    fsync_rx #(.DEPTH(FIFO_DEPTH)) i_en_rx (
      .clk_i, .rst_ni, .valid_i(en_valid[d]), .req_i(en_req[d]), .pop_i(en_pop),
      .empty_o(en_empty), .local_o(en_local), .req_o(en_head), .overflow_o(ovf[d][0])
    );

    fsync_rx #(.DEPTH(FIFO_DEPTH)) i_ws_rx (
      .clk_i, .rst_ni, .valid_i(ws_valid[d]), .req_i(ws_req[d]), .pop_i(ws_pop),
      .empty_o(ws_empty), .local_o(ws_local), .req_o(ws_head), .overflow_o(ovf[d][1])
    );

    fsync_cc #(.DEPTH(FIFO_DEPTH)) i_cc (
      .clk_i, .rst_ni,
      .en_empty_i(en_empty), .en_local_i(en_local), .en_req_i(en_head), .en_pop_o(en_pop),
      .ws_empty_i(ws_empty), .ws_local_i(ws_local), .ws_req_i(ws_head), .ws_pop_o(ws_pop),
      .req_out_valid_o(out_valid[d]), .req_out_o(out_req[d]),
      .wake_empty_o(cc_wake_empty), .wake_id_o(cc_wake_id), .wake_pop_i(arb_pop[0]),
      .overflow_o(ovf[d][2])
    );

    // Wakes coming down from the parent
    fsync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(ID_W)) i_tx_fifo (
      .clk_i, .rst_ni, .push_i(rsp_valid[d]), .data_i(rsp_id[d]), .pop_i(arb_pop[1]),
      .empty_o(tx_empty), .data_o(tx_id), .overflow_o(ovf[d][3])
    );

    fsync_arbiter i_wake_arb (
      .clk_i, .rst_ni, .empty_i({tx_empty, cc_wake_empty}), .data_i({tx_id, cc_wake_id}),
      .pop_o(arb_pop), .valid_o(wake_valid[d]), .data_o(wake_id[d])
    );
  end

  assign error_o = |ovf; // Every source is sticky, so the OR is too

endmodule

// File: hw/fsync_pkg.sv
// Fractal barrier-synchronization node package
// Widths of the request word and sizes derived from them

package fsync_pkg;

  // Request word layout is {aggregate, id}
  parameter int unsigned AGGR_W = 4;
  parameter int unsigned ID_W   = 4;
  parameter int unsigned REQ_W  = AGGR_W + ID_W;

  // Directly mapped tables hold one entry per id
  parameter int unsigned N_IDS = 2 ** ID_W;

  parameter int unsigned FIFO_DEPTH = 4;

  // Dimension indices
  parameter int unsigned DIM_H = 0;
  parameter int unsigned DIM_V = 1;

endpackage

// File: hw/fsync_rx.sv
// Receive unit for one child port
// Buffers incoming requests and classifies the head as local or remote

`timescale 1ns/1ps

module fsync_rx
  import fsync_pkg::*;
#(
  parameter int unsigned DEPTH = FIFO_DEPTH
)(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             valid_i,
  input  logic [REQ_W-1:0] req_i,
  input  logic             pop_i,
  output logic             empty_o,
  output logic             local_o,
  output logic [REQ_W-1:0] req_o,
  output logic             overflow_o
);

  logic [REQ_W-1:0]  head;
  logic [AGGR_W-1:0] head_aggr;
  logic [ID_W-1:0]   head_id;

  fsync_fifo #(
    .DEPTH ( DEPTH ),
    .WIDTH ( REQ_W )
  ) i_fifo (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .push_i     ( valid_i    ),
    .data_i     ( req_i      ),
    .pop_i      ( pop_i      ),
    .empty_o    ( empty_o    ),
    .data_o     ( head       ),
    .overflow_o ( overflow_o )
  );

  assign head_aggr = head[REQ_W-1:ID_W];
  assign head_id   = head[ID_W-1:0];

  // Only bit 0 set means the barrier closes at this node
  assign local_o = ~|head_aggr[AGGR_W-1:1];

  // Remote heads leave with the aggregate already moved one level up
  assign req_o = local_o ? head : {1'b0, head_aggr[AGGR_W-1:1], head_id};

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f src.f --top-module tb_fsync_node -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "All tests passed" sim.log; then
  exit 0
else
  exit 1
fi

// File: src.f
hw/fsync_pkg.sv
hw/fsync_fifo.sv
hw/fsync_rx.sv
hw/fsync_arbiter.sv
hw/fsync_cc.sv
hw/fsync_node.sv
bench/fsync_checker.sv
bench/tb_fsync_node.sv
